/* source/fat_reader_pkg.sv */
// shared constants, beat and geometry structs, walker states and name folding
// for the FAT16 file reader; every RTL file refers to it by scoped names
`default_nettype none

package fat_reader_pkg;

    localparam int unsigned sector_bytes    = 512;
    localparam int unsigned dir_entry_bytes = 32;
    localparam int unsigned name_len        = 11;    // 8.3 without the dot
    localparam logic [15:0] fat16_eoc_min   = 16'hFFF0;

    // one byte of a sector as it streams in
    typedef struct packed {
        logic       valid;
        logic [8:0] addr;
        logic [7:0] data;
    } sector_beat_t;

    typedef struct packed {
        logic [31:0] fat_start;
        logic [31:0] root_start;
        logic [15:0] root_sectors;
        logic [31:0] data_start;     // lba of cluster 0, so cluster 2 is the first
        logic [7:0]  cluster_size;
    } volume_geom_t;

    typedef struct packed {
        logic [15:0] cluster;
        logic [31:0] size;
    } file_info_t;

    typedef enum logic [2:0] {
        reset,
        search_mbr,
        search_dbr,
        list_root,
        read_file,
        done
    } walk_state_e;

    typedef enum logic [1:0] {
        unassigned,
        unknown,
        fat16
    } fs_kind_e;

    function automatic logic [7:0] to_upper(input logic [7:0] c);
        return (c >= "a" && c <= "z") ? (c & 8'hDF) : c;
    endfunction

endpackage

`default_nettype wire

/* source/boot_sector_parser.sv */
// picks MBR/DBR fields out of the sector stream as they pass and derives
// the boot flags and the FAT16 layout relative to the sector being read
`timescale 1ns/10ps
`default_nettype none

module boot_sector_parser (
    input  logic                         clk,
    input  logic                         rst_n,
    input  fat_reader_pkg::sector_beat_t beat,
    input  logic [31:0]                  sector_base,
    output logic                         is_boot,
    output logic                         is_dbr,
    output logic [31:0]                  part_sector,
    output fat_reader_pkg::fs_kind_e     fs_kind,
    output fat_reader_pkg::volume_geom_t geom
);

    logic [7:0]  jump;
    logic [15:0] sig;
    logic [31:0] part;
    logic [15:0] bps;
    logic [7:0]  spc;
    logic [15:0] resv;
    logic [7:0]  nfat;
    logic [15:0] root_ent;
    logic [15:0] spf;
    logic [8:0]  last_addr;

    always_ff @(posedge clk) begin
        if (beat.valid) begin
            case (beat.addr)
                9'h000: jump           <= beat.data;
                9'h00B: bps[7:0]       <= beat.data;
                9'h00C: bps[15:8]      <= beat.data;
                9'h00D: spc            <= beat.data;
                9'h00E: resv[7:0]      <= beat.data;
                9'h00F: resv[15:8]     <= beat.data;
                9'h010: nfat           <= beat.data;
                9'h011: root_ent[7:0]  <= beat.data;
                9'h012: root_ent[15:8] <= beat.data;
                9'h016: spf[7:0]       <= beat.data;
                9'h017: spf[15:8]      <= beat.data;
                9'h1C6: part[7:0]      <= beat.data;  // first partition entry, lba start
                9'h1C7: part[15:8]     <= beat.data;
                9'h1C8: part[23:16]    <= beat.data;
                9'h1C9: part[31:24]    <= beat.data;
                9'h1FE: sig[15:8]      <= beat.data;
                9'h1FF: sig[7:0]       <= beat.data;
                default: ;
            endcase
        end
    end

    assign is_boot     = (sig == 16'h55AA);
    assign is_dbr      = (jump == 8'hEB) || (jump == 8'hE9);
    assign part_sector = part;
    // FAT32 leaves the 16-bit FAT size at zero
    assign fs_kind     = (bps == 16'(fat_reader_pkg::sector_bytes) && spf != 16'd0) ?
                         fat_reader_pkg::fat16 : fat_reader_pkg::unknown;

    always_comb begin
        geom.cluster_size = spc;
        geom.fat_start    = sector_base + 32'(resv);
        geom.root_start   = geom.fat_start + 32'(nfat) * 32'(spf);
        geom.root_sectors = root_ent /
            16'(fat_reader_pkg::sector_bytes / fat_reader_pkg::dir_entry_bytes);
        geom.data_start   = geom.root_start + 32'(geom.root_sectors) - 32'(spc) * 32'd2;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_addr <= '0;
        end else if (beat.valid) begin
            last_addr <= beat.addr;
        end
    end

    // a stream restarts at 0, otherwise addresses only climb
    assert property (@(posedge clk) disable iff (!rst_n)
        beat.valid && beat.addr != 9'd0 |-> beat.addr > last_addr);

endmodule

`default_nettype wire

/* source/dir_entry_matcher.sv */
// collects 32-byte root directory entries while listing is enabled and
// flags the first live file entry whose 8.3 name equals the target, any case
`timescale 1ns/10ps
`default_nettype none

module dir_entry_matcher #(
    parameter logic [8*fat_reader_pkg::name_len-1:0] file_name = "README  TXT"
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         list_en,
    input  fat_reader_pkg::sector_beat_t beat,
    output logic                         found,
    output fat_reader_pkg::file_info_t   finfo
);

    localparam int unsigned nl = fat_reader_pkg::name_len;

    logic [8*nl-1:0] target_upper;
    logic [8*nl-1:0] name_q;    // first name byte in the top byte
    logic [7:0]      attr_q;
    logic [15:0]     clus_q;
    logic [23:0]     size_q;
    logic [4:0]      idx;
    logic            entry_used;
    logic            is_file;
    logic            hit;

    always_comb begin
        for (int i = 0; i < nl; i++) begin
            target_upper[8*i +: 8] = fat_reader_pkg::to_upper(file_name[8*i +: 8]);
        end
    end

    assign idx = beat.addr[4:0];

    always_ff @(posedge clk) begin
        if (list_en && beat.valid) begin
            if (idx < 5'(nl)) begin
                name_q[8*(nl-1-idx) +: 8] <= beat.data;
            end
            case (idx)
                5'd11: attr_q         <= beat.data;
                5'd26: clus_q[7:0]    <= beat.data;
                5'd27: clus_q[15:8]   <= beat.data;
                5'd28: size_q[7:0]    <= beat.data;
                5'd29: size_q[15:8]   <= beat.data;
                5'd30: size_q[23:16]  <= beat.data;
                default: ;
            endcase
        end
    end

    // 0x00 ends the table, 0xE5 marks a deleted entry
    assign entry_used = name_q[8*nl-1 -: 8] != 8'h00 && name_q[8*nl-1 -: 8] != 8'hE5;
    assign is_file    = !attr_q[4] && !attr_q[3];   // not a subdirectory, not the label
    assign hit = list_en && beat.valid && idx == 5'(fat_reader_pkg::dir_entry_bytes - 1) &&
                 entry_used && is_file && name_q == target_upper;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            found <= 1'b0;
        end else if (hit) begin
            found <= 1'b1;
        end
    end

    // size byte 31 is still on the bus at the hit
    always_ff @(posedge clk) begin
        if (hit && !found) begin
            finfo.cluster <= clus_q;
            finfo.size    <= {beat.data, size_q};
        end
    end

endmodule

`default_nettype wire

/* source/fat_entry_capture.sv */
// grabs the 16-bit FAT entry of the current cluster from a streaming FAT
// sector; a sector holds 256 entries so the low cluster byte selects the slot
`timescale 1ns/10ps
`default_nettype none

module fat_entry_capture (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         fat_en,
    input  logic [15:0]                  cur_cluster,
    input  fat_reader_pkg::sector_beat_t beat,
    output logic [15:0]                  next_cluster
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            next_cluster <= '0;
        end else if (fat_en && beat.valid && beat.addr[8:1] == cur_cluster[7:0]) begin
            next_cluster[8*beat.addr[0] +: 8] <= beat.data;   // little endian
        end
    end

    // clusters 0 and 1 are reserved and never walked
    assert property (@(posedge clk) disable iff (!rst_n)
        fat_en |-> cur_cluster >= 16'd2);

endmodule

`default_nettype wire

/* source/fat_walker.sv */
// sector request FSM: finds the boot sector, lists the root directory, then
// walks the file's cluster chain and streams file bytes up to the file size
`timescale 1ns/10ps
`default_nettype none

module fat_walker (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         read_done,
    input  fat_reader_pkg::sector_beat_t beat,
    input  logic                         is_boot,
    input  logic                         is_dbr,
    input  logic [31:0]                  part_sector,
    input  fat_reader_pkg::fs_kind_e     fs_kind,
    input  fat_reader_pkg::volume_geom_t geom,
    input  logic                         found,
    input  fat_reader_pkg::file_info_t   finfo,
    input  logic [15:0]                  next_cluster,
    output logic                         read_start,
    output logic [31:0]                  read_sector,
    output logic                         list_en,
    output logic                         fat_en,
    output logic [15:0]                  cur_cluster,
    output fat_reader_pkg::walk_state_e  state,
    output fat_reader_pkg::fs_kind_e     fs_type,
    output logic                         out_valid,
    output logic [7:0]                   out_byte
);

    fat_reader_pkg::volume_geom_t geom_q;   // parser fields are overwritten by later sectors
    logic        pending;
    logic        fat_phase;                 // current read is a FAT sector
    logic [15:0] sec_off;
    logic [31:0] byte_cnt;
    logic        file_beat;

    function automatic logic [31:0] cluster_lba(input logic [15:0] c, input logic [15:0] off);
        return geom_q.data_start + 32'(geom_q.cluster_size) * 32'(c) + 32'(off);
    endfunction

    assign list_en = (state == fat_reader_pkg::list_root);
    assign fat_en  = (state == fat_reader_pkg::read_file) && fat_phase;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= fat_reader_pkg::reset;
            fs_type     <= fat_reader_pkg::unassigned;
            read_start  <= 1'b0;
            pending     <= 1'b0;
            read_sector <= '0;
            sec_off     <= '0;
            fat_phase   <= 1'b0;
            cur_cluster <= '0;
            geom_q      <= '0;
        end else begin
            read_start <= 1'b0;
            if (read_done) begin
                // next request goes out right away unless the walk ends below
                read_start <= 1'b1;
                pending    <= 1'b1;
                case (state)
                    fat_reader_pkg::search_mbr: begin
                        if (is_boot) begin
                            state <= fat_reader_pkg::search_dbr;
                            if (!is_dbr) begin
                                read_sector <= part_sector;
                            end
                        end else begin
                            read_sector <= read_sector + 32'd1;
                        end
                    end
                    fat_reader_pkg::search_dbr: begin
                        fs_type <= (is_boot && is_dbr) ? fs_kind : fat_reader_pkg::unknown;
                        if (is_boot && is_dbr && fs_kind == fat_reader_pkg::fat16) begin
                            geom_q      <= geom;
                            sec_off     <= '0;
                            read_sector <= geom.root_start;
                            state       <= fat_reader_pkg::list_root;
                        end else begin
                            state      <= fat_reader_pkg::done;
                            read_start <= 1'b0;
                            pending    <= 1'b0;
                        end
                    end
                    fat_reader_pkg::list_root: begin
                        sec_off <= sec_off + 16'd1;
                        if (found && finfo.cluster >= 16'd2) begin
                            sec_off     <= '0;
                            cur_cluster <= finfo.cluster;
                            read_sector <= cluster_lba(finfo.cluster, 16'd0);
                            state       <= fat_reader_pkg::read_file;
                        end else if (!found && sec_off + 16'd1 < geom_q.root_sectors) begin
                            read_sector <= geom_q.root_start + 32'(sec_off) + 32'd1;
                        end else begin
                            state      <= fat_reader_pkg::done;   // empty file or no match
                            read_start <= 1'b0;
                            pending    <= 1'b0;
                        end
                    end
                    fat_reader_pkg::read_file: begin
                        if (!fat_phase) begin
                            if (sec_off + 16'd1 < 16'(geom_q.cluster_size)) begin
                                sec_off     <= sec_off + 16'd1;
                                read_sector <= cluster_lba(cur_cluster, sec_off + 16'd1);
                            end else begin
                                fat_phase   <= 1'b1;
                                read_sector <= geom_q.fat_start + 32'(cur_cluster[15:8]);
                            end
                        end else begin
                            fat_phase <= 1'b0;
                            sec_off   <= '0;
                            if (next_cluster >= fat_reader_pkg::fat16_eoc_min ||
                                next_cluster < 16'd2) begin
                                state      <= fat_reader_pkg::done;
                                read_start <= 1'b0;
                                pending    <= 1'b0;
                            end else begin
                                cur_cluster <= next_cluster;
                                read_sector <= cluster_lba(next_cluster, 16'd0);
                            end
                        end
                    end
                    default: ;
                endcase
            end else if (state == fat_reader_pkg::reset) begin
                state <= fat_reader_pkg::search_mbr;
            end else if (state != fat_reader_pkg::done && !pending) begin
                read_start <= 1'b1;   // first request after reset
                pending    <= 1'b1;
            end
        end
    end

    assign file_beat = beat.valid && state == fat_reader_pkg::read_file && !fat_phase &&
                       byte_cnt < finfo.size;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            byte_cnt  <= '0;
        end else begin
            out_valid <= file_beat;
            if (file_beat) begin
                byte_cnt <= byte_cnt + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (file_beat) begin
            out_byte <= beat.data;
        end
    end

    // one request in flight at a time
    assert property (@(posedge clk) disable iff (!rst_n)
        read_start |=> !read_start until read_done);

    // emitted bytes never run past the matched file size
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> byte_cnt <= finfo.size);

endmodule

`default_nettype wire

/* source/fat16_file_reader.sv */
// top level of the FAT16 file reader; the sector source sits outside and
// answers each read_start with 512 beats and a read_done pulse
`timescale 1ns/10ps
`default_nettype none

module fat16_file_reader #(
    parameter logic [8*fat_reader_pkg::name_len-1:0] file_name = "README  TXT"
) (
    input  logic                         clk,
    input  logic                         rst_n,
    output logic                         read_start,
    output logic [31:0]                  read_sector,
    input  logic                         read_done,
    input  fat_reader_pkg::sector_beat_t beat,
    output fat_reader_pkg::walk_state_e  state,
    output fat_reader_pkg::fs_kind_e     fs_type,
    output logic                         file_found,
    output logic                         out_valid,
    output logic [7:0]                   out_byte
);

    logic                         is_boot;
    logic                         is_dbr;
    logic [31:0]                  part_sector;
    fat_reader_pkg::fs_kind_e     fs_kind;
    fat_reader_pkg::volume_geom_t geom;
    fat_reader_pkg::file_info_t   finfo;
    logic                         list_en;
    logic                         fat_en;
    logic [15:0]                  cur_cluster;
    logic [15:0]                  next_cluster;

    boot_sector_parser u_parser (
        .clk         (clk),
        .rst_n       (rst_n),
        .beat        (beat),
        .sector_base (read_sector),
        .is_boot     (is_boot),
        .is_dbr      (is_dbr),
        .part_sector (part_sector),
        .fs_kind     (fs_kind),
        .geom        (geom)
    );

    dir_entry_matcher #(.file_name(file_name)) u_matcher (
        .clk     (clk),
        .rst_n   (rst_n),
        .list_en (list_en),
        .beat    (beat),
        .found   (file_found),
        .finfo   (finfo)
    );

    fat_entry_capture u_fat_capture (
        .clk          (clk),
        .rst_n        (rst_n),
        .fat_en       (fat_en),
        .cur_cluster  (cur_cluster),
        .beat         (beat),
        .next_cluster (next_cluster)
    );

    fat_walker u_walker (
        .clk          (clk),
        .rst_n        (rst_n),
        .read_done    (read_done),
        .beat         (beat),
        .is_boot      (is_boot),
        .is_dbr       (is_dbr),
        .part_sector  (part_sector),
        .fs_kind      (fs_kind),
        .geom         (geom),
        .found        (file_found),
        .finfo        (finfo),
        .next_cluster (next_cluster),
        .read_start   (read_start),
        .read_sector  (read_sector),
        .list_en      (list_en),
        .fat_en       (fat_en),
        .cur_cluster  (cur_cluster),
        .state        (state),
        .fs_type      (fs_type),
        .out_valid    (out_valid),
        .out_byte     (out_byte)
    );

endmodule

`default_nettype wire

/* tests/tb_fat16_file_reader.sv */
// testbench for the FAT16 file reader; plays the sector source from sparse disk
// images in tests/disk_input.txt and checks streamed bytes, state and counts
`timescale 1ns/10ps
`default_nettype none

module tb_fat16_file_reader;

    localparam int max_cases     = 4;
    localparam int max_sectors   = 128;
    localparam int clk_period    = 40;
    localparam int sector_cycles = 600;

    logic                         clk;
    logic                         rst_n;
    logic                         read_done;
    fat_reader_pkg::sector_beat_t beat;
    logic                         read_start;
    logic [31:0]                  read_sector;
    fat_reader_pkg::walk_state_e  state;
    fat_reader_pkg::fs_kind_e     fs_type;
    logic                         file_found;
    logic                         out_valid;
    logic [7:0]                   out_byte;

    logic [7:0]  image [max_cases*max_sectors*512];
    bit          listed [max_cases*max_sectors];
    string       case_name [max_cases];
    int          exp_state [max_cases];
    int          exp_found [max_cases];
    int          exp_size [max_cases];
    int          exp_reads [max_cases];
    logic [7:0]  exp_bytes [$];
    int          n_cases;
    int          total_sectors;
    int          cur_case;
    int          errors;
    int          failed_cases;
    int          got_bytes;
    int          reads;
    int          cycle_cnt;
    int          cycle_limit;
    bit          running;
    logic [31:0] lfsr;

    // target given in lower case, the volume stores names upper case
    fat16_file_reader #(.file_name("readme  txt")) u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .read_start  (read_start),
        .read_sector (read_sector),
        .read_done   (read_done),
        .beat        (beat),
        .state       (state),
        .fs_type     (fs_type),
        .file_found  (file_found),
        .out_valid   (out_valid),
        .out_byte    (out_byte)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic compare_value(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
        if (exp !== act) begin
            $display("Mismatch %s: expected %0h, actual %0h", what, exp, act);
            errors++;
        end
    endtask

    function automatic bit next_lfsr_bit();
        bit b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic logic [7:0] byte_at(input int c, input longint sec, input int off);
        if (sec < 0 || sec >= max_sectors) begin
            return 8'h00;   // outside the image reads as zero
        end
        return image[(c * max_sectors + int'(sec)) * 512 + off];
    endfunction

    function automatic logic [15:0] word_at(input int c, input longint sec, input int off);
        return {byte_at(c, sec, off + 1), byte_at(c, sec, off)};
    endfunction

    // walks the image by the FAT16 rules and queues the bytes the reader must send
    task automatic build_expected(input int c, output int fs);
        longint dbr;
        int     spc;
        int     fat_start;
        int     root_start;
        int     root_secs;
        int     data_start;
        int     clus;
        int     left;
        int     guard;
        int     base;
        bit     hit;
        bit     same;
        logic [7:0] ch;
        string  target;

        target = "readme  txt";
        fs = 1;
        exp_bytes.delete();
        if (word_at(c, 0, 'h1FE) != 'hAA55) begin
            return;
        end
        ch = byte_at(c, 0, 0);
        dbr = (ch == 8'hEB || ch == 8'hE9) ? 0 :
              {byte_at(c, 0, 'h1C9), byte_at(c, 0, 'h1C8), word_at(c, 0, 'h1C6)};
        ch = byte_at(c, dbr, 0);
        if (word_at(c, dbr, 'h1FE) != 'hAA55 || !(ch == 8'hEB || ch == 8'hE9)) begin
            return;
        end
        if (word_at(c, dbr, 'h0B) != 512 || word_at(c, dbr, 'h16) == 0) begin
            return;
        end
        fs = 2;
        spc        = byte_at(c, dbr, 'h0D);
        fat_start  = int'(dbr) + word_at(c, dbr, 'h0E);
        root_start = fat_start + byte_at(c, dbr, 'h10) * word_at(c, dbr, 'h16);
        root_secs  = word_at(c, dbr, 'h11) / 16;
        data_start = root_start + root_secs - 2 * spc;
        hit = 0;
        for (int s = 0; s < root_secs && !hit; s++) begin
            for (int e = 0; e < 16 && !hit; e++) begin
                base = e * 32;
                ch = byte_at(c, root_start + s, base);
                same = (ch != 8'h00 && ch != 8'hE5) &&
                       (byte_at(c, root_start + s, base + 11) & 8'h18) == 0;
                for (int i = 0; i < 11; i++) begin
                    ch = target[i];
                    if (ch >= "a" && ch <= "z") begin
                        ch = ch - 8'd32;
                    end
                    if (byte_at(c, root_start + s, base + i) != ch) begin
                        same = 0;
                    end
                end
                if (same) begin
                    hit  = 1;
                    clus = word_at(c, root_start + s, base + 26);
                    left = {word_at(c, root_start + s, base + 30),
                            word_at(c, root_start + s, base + 28)};
                end
            end
        end
        if (!hit || clus < 2) begin
            return;
        end
        guard = 0;
        while (left > 0 && guard < 1000) begin
            for (int s = 0; s < spc; s++) begin
                for (int off = 0; off < 512 && left > 0; off++) begin
                    exp_bytes.push_back(byte_at(c, data_start + spc * clus + s, off));
                    left--;
                end
            end
            clus = word_at(c, fat_start + clus / 256, (clus % 256) * 2);
            if (clus >= 'hFFF0 || clus < 2) begin
                left = 0;
            end
            guard++;
        end
    endtask

    task automatic load_cases();
        int          fd;
        int          r;
        int          sec;
        int          off;
        int          cnt;
        logic [7:0]  b;
        string       tok;
        string       line;

        for (int i = 0; i < max_cases * max_sectors * 512; i++) begin
            image[i] = 8'h00;
        end
        fd = $fopen("tests/disk_input.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/disk_input.txt");
            $display("STATUS: FAIL");
            $finish;
        end else begin
            n_cases = 0;
            total_sectors = 0;
            while (!$feof(fd)) begin
                r = $fscanf(fd, "%s", tok);
                if (r != 1) begin
                    break;
                end
                if (tok == "#") begin
                    r = $fgets(line, fd);
                end else if (tok == "case" && n_cases < max_cases) begin
                    r = $fscanf(fd, "%s %d %d %d %d", tok, exp_state[n_cases],
                                exp_found[n_cases], exp_size[n_cases], exp_reads[n_cases]);
                    case_name[n_cases] = tok;
                    n_cases++;
                end else if (tok == "w" && n_cases > 0) begin
                    r = $fscanf(fd, "%h %h %d", sec, off, cnt);
                    if (sec >= max_sectors || off + cnt > 512) begin
                        $display("data file record out of range at sector %0h", sec);
                        errors++;
                    end else begin
                        for (int i = 0; i < cnt; i++) begin
                            r = $fscanf(fd, "%h", b);
                            image[((n_cases - 1) * max_sectors + sec) * 512 + off + i] = b;
                        end
                        if (!listed[(n_cases - 1) * max_sectors + sec]) begin
                            listed[(n_cases - 1) * max_sectors + sec] = 1;
                            total_sectors++;
                        end
                    end
                end else begin
                    $display("data file has an unexpected word: %s", tok);
                    errors++;
                end
            end
            $fclose(fd);
        end
    endtask

    // sector source: answers each request with 512 beats, gaps, then read_done
    initial begin : card
        int  sec;
        int  a;
        bit  g0;
        bit  g1;
        forever begin
            @(posedge clk);
            if (rst_n && read_start) begin
                sec = read_sector;
                reads++;
                a = 0;
                while (a < 512) begin
                    @(posedge clk);
                    g0 = next_lfsr_bit();
                    g1 = next_lfsr_bit();
                    if (g0 && g1) begin
                        beat <= '0;    // idle gap
                    end else begin
                        beat <= {1'b1, 9'(a), byte_at(cur_case, sec, a)};
                        a++;
                    end
                end
                @(posedge clk);
                beat      <= '0;
                read_done <= 1'b1;
                @(posedge clk);
                read_done <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n && out_valid) begin
            if (exp_bytes.size() == 0) begin
                $display("case %s: byte %0d arrived past the end of the file",
                         case_name[cur_case], got_bytes);
                errors++;
            end else begin
                compare_value($sformatf("%s byte %0d", case_name[cur_case], got_bytes),
                              exp_bytes.pop_front(), out_byte);
            end
            got_bytes++;
        end
    end

    always @(posedge clk) begin
        if (running) begin
            cycle_cnt++;
            if (cycle_cnt >= cycle_limit) begin
                $display("timeout: reader did not finish within %0d cycles", cycle_limit);
                $display("STATUS: FAIL");
                $finish;
            end
        end
    end

    task automatic run_case(input int c);
        int fs;
        int errs_before;

        errs_before = errors;
        cur_case = c;
        build_expected(c, fs);
        @(posedge clk);
        rst_n <= 1'b0;
        got_bytes = 0;
        reads = 0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        while (state !== fat_reader_pkg::done) begin
            @(posedge clk);
        end
        @(posedge clk);
        compare_value({case_name[c], " state"}, exp_state[c], state);
        compare_value({case_name[c], " file_found"}, exp_found[c], file_found);
        compare_value({case_name[c], " fs_type"}, fs, fs_type);
        compare_value({case_name[c], " byte count"}, exp_size[c], got_bytes);
        compare_value({case_name[c], " sector reads"}, exp_reads[c], reads);
        if (exp_bytes.size() != 0) begin
            $display("case %s: %0d file bytes never arrived", case_name[c], exp_bytes.size());
            errors++;
        end
        if (errors == errs_before) begin
            $display("case %s: ok", case_name[c]);
        end else begin
            $display("case %s: failed with %0d errors", case_name[c], errors - errs_before);
            failed_cases++;
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        read_done    = 1'b0;
        beat         = '0;
        lfsr         = 32'd84243;
        running      = 0;
        errors       = 0;
        failed_cases = 0;
        cycle_cnt    = 0;
        cur_case     = 0;
        load_cases();
        cycle_limit = 2 * total_sectors * sector_cycles;
        running = 1;
        for (int c = 0; c < n_cases; c++) begin
            run_case(c);
        end
        $display("cases %0d, passed %0d, failed %0d, errors %0d",
                 n_cases, n_cases - failed_cases, failed_cases, errors);
        if (errors == 0 && n_cases > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/disk_input.txt */
# case <name> <final state, 5 is done> <file_found> <file size> <sector reads>
# w <sector hex> <offset hex> <byte count> <bytes hex ...>, unlisted bytes are 0
# mbr at 0 points to dbr at 63, chain 3 -> 7 -> 5 -> ffff, size 1112
case mbr_chain 5 1 1112 9
w 0 1c6 4 3f 00 00 00
w 0 1fe 2 55 aa
w 3f 0 3 eb 3c 90
w 3f b 8 00 02 01 01 00 02 10 00
w 3f 16 2 01 00
w 3f 1fe 2 55 aa
w 40 0 4 f8 ff ff ff
w 40 6 2 07 00
w 40 a 2 ff ff
w 40 e 2 05 00
# root: deleted, subdirectory, other spacing, then the file
w 42 0 12 e5 45 41 44 4d 45 20 20 54 58 54 20
w 42 20 12 52 45 41 44 4d 45 20 20 54 58 54 10
w 42 40 12 52 45 41 44 20 4d 45 20 54 58 54 20
w 42 60 12 52 45 41 44 4d 45 20 20 54 58 54 20
w 42 7a 6 03 00 58 04 00 00
w 44 0 4 11 22 33 44
w 44 1fc 4 a1 a2 a3 a4
w 48 0 4 55 66 77 88
w 48 1ff 1 b7
w 46 0 2 99 aa
w 46 54 5 c1 c2 c3 c4 c5
# dbr at sector 0, two root sectors, no matching file
case missing_file 5 0 0 4
w 0 0 3 eb 3c 90
w 0 b 8 00 02 01 01 00 02 20 00
w 0 16 2 01 00
w 0 1fe 2 55 aa
w 3 0 12 4f 54 48 45 52 20 20 20 54 58 54 20
w 3 1a 6 02 00 10 00 00 00
w 4 0 12 52 45 41 44 4d 45 20 20 54 58 31 20
w 4 20 12 52 45 41 44 4d 45 20 20 54 58 54 08
# 1024-byte sectors, root must never be read
case bad_sector_size 5 0 0 2
w 0 0 3 eb 3c 90
w 0 b 8 00 04 01 01 00 02 10 00
w 0 16 2 01 00
w 0 1fe 2 55 aa
w 3 0 12 52 45 41 44 4d 45 20 20 54 58 54 20

/* flist.f */
source/fat_reader_pkg.sv
source/boot_sector_parser.sv
source/dir_entry_matcher.sv
source/fat_entry_capture.sv
source/fat_walker.sv
source/fat16_file_reader.sv
tests/tb_fat16_file_reader.sv

/* Bender.yml */
package:
  name: fat16_file_reader

sources:
  - source/fat_reader_pkg.sv
  - source/boot_sector_parser.sv
  - source/dir_entry_matcher.sv
  - source/fat_entry_capture.sv
  - source/fat_walker.sv
  - source/fat16_file_reader.sv
  - target: test
    files:
      - tests/tb_fat16_file_reader.sv
